// File: source/apf_io_pkg.sv
/* address map, register indices and payload types shared by the host I/O block.
   only regions 1, 4 and 15 are mapped; config indices past 8 read as zero */
package apf_io_pkg;

	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;

	// top address nibble picks the target
	typedef logic [3:0] region_t;
	localparam region_t REGION_CRAM0 = 4'd1;
	localparam region_t REGION_SDRAM = 4'd4;
	localparam region_t REGION_CONFIG = 4'd15;

	// config register index, byte address bits 7..2
	typedef logic [5:0] cfg_index_t;
	localparam cfg_index_t CFG_CTRL_MAP_1 = 6'd0;
	localparam cfg_index_t CFG_CTRL_MAP_2 = 6'd1;
	localparam cfg_index_t CFG_DIPSW = 6'd2;
	localparam cfg_index_t CFG_SYSTEM_TYPE = 6'd3;
	localparam cfg_index_t CFG_VIDEO_MODE = 6'd4;
	localparam cfg_index_t CFG_SND_ENABLE = 6'd5;
	localparam cfg_index_t CFG_CH_ENABLE = 6'd6;
	localparam cfg_index_t CFG_SCREEN_X = 6'd7;
	localparam cfg_index_t CFG_SCREEN_Y = 6'd8;

	// register widths
	localparam int CTRL_MAP_W = 4;
	localparam int DIPSW_W = 8;
	localparam int SYS_TYPE_W = 2;
	localparam int VIDEO_MODE_W = 1;
	localparam int SND_EN_W = 4;
	localparam int CH_EN_W = 6;
	localparam int SCREEN_POS_W = 8;

	// controller layouts, any other code is the plain pad layout
	typedef logic [CTRL_MAP_W-1:0] ctrl_map_t;
	localparam ctrl_map_t LAYOUT_NEOGEO = 4'd1;
	localparam ctrl_map_t LAYOUT_NEOGEO_CD = 4'd2;

	// pad key bitmap positions
	typedef logic [15:0] pad_keys_t;
	localparam int KEY_UP = 0;
	localparam int KEY_DOWN = 1;
	localparam int KEY_LEFT = 2;
	localparam int KEY_RIGHT = 3;
	localparam int KEY_A = 4;
	localparam int KEY_B = 5;
	localparam int KEY_X = 6;
	localparam int KEY_Y = 7;
	localparam int KEY_L1 = 8;
	localparam int KEY_SELECT = 14;
	localparam int KEY_START = 15;

	typedef logic [9:0] joystick_t;

	// RAM ports, addresses in words
	typedef logic [31:0] cram_word_t;
	typedef logic [23:0] cram_addr_t;
	typedef logic [15:0] sdram_word_t;
	typedef logic [25:0] sdram_addr_t;

	localparam int P_ROM_MASK_W = 24;
	localparam int C_ROM_MASK_W = 26;
	typedef logic [P_ROM_MASK_W-1:0] p_rom_mask_t;
	typedef logic [C_ROM_MASK_W-1:0] c_rom_mask_t;

endpackage

// File: source/bridge_decode.sv
`timescale 1ns/1ps
/* one read in flight at a time; no new request is taken until its response.
   writes get no response, unmapped reads return zero */
module bridge_decode (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic bus_valid,
	input  logic bus_wr,
	input  apf_io_pkg::bus_addr_t bus_addr,
	input  apf_io_pkg::bus_data_t bus_wdata,
	output logic bus_ready,
	output logic rsp_valid,
	output apf_io_pkg::bus_data_t rsp_rdata,
	output logic cfg_req_valid,
	input  logic cfg_req_ready,
	input  logic cfg_rsp_valid,
	input  apf_io_pkg::bus_data_t cfg_rsp_rdata,
	output logic cram0_req_valid,
	input  logic cram0_req_ready,
	input  logic cram0_rsp_valid,
	input  apf_io_pkg::bus_data_t cram0_rsp_rdata,
	output logic sdram_req_valid,
	input  logic sdram_req_ready,
	input  logic sdram_rsp_valid,
	input  apf_io_pkg::bus_data_t sdram_rsp_rdata,
	output logic req_wr,
	output apf_io_pkg::bus_addr_t req_addr,
	output apf_io_pkg::bus_data_t req_wdata,
	output logic wr_p_rom,
	output logic wr_c_rom
);
	import apf_io_pkg::*;

	region_t region;
	logic sel_cfg;
	logic sel_cram0;
	logic sel_sdram;
	logic sel_none;
	logic target_ready;
	logic accept;
	logic rd_pending;
	logic unmapped_rsp;

	assign region = bus_addr[31:28];
	assign sel_cfg = (region == REGION_CONFIG);
	assign sel_cram0 = (region == REGION_CRAM0);
	assign sel_sdram = (region == REGION_SDRAM);
	assign sel_none = !(sel_cfg || sel_cram0 || sel_sdram);

	// requests are held back while a read waits for its data
	assign cfg_req_valid = bus_valid && !rd_pending && sel_cfg;
	assign cram0_req_valid = bus_valid && !rd_pending && sel_cram0;
	assign sdram_req_valid = bus_valid && !rd_pending && sel_sdram;

	// unmapped accesses are always taken
	assign target_ready = (sel_cfg && cfg_req_ready) || (sel_cram0 && cram0_req_ready) ||
		(sel_sdram && sdram_req_ready) || sel_none;
	assign bus_ready = bus_valid && !rd_pending && target_ready;
	assign accept = bus_valid && bus_ready;

	assign req_wr = bus_wr;
	assign req_addr = bus_addr;
	assign req_wdata = bus_wdata;

	// write strobes for the ROM mask tracker
	assign wr_p_rom = accept && bus_wr && sel_cram0;
	assign wr_c_rom = accept && bus_wr && sel_sdram;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rd_pending <= 1'b0;
			unmapped_rsp <= 1'b0;
		end else begin
			unmapped_rsp <= accept && !bus_wr && sel_none;
			if (accept && !bus_wr) begin
				rd_pending <= 1'b1;
			end else if (rsp_valid) begin
				rd_pending <= 1'b0;
			end
		end
	end

	assign rsp_valid = cfg_rsp_valid || cram0_rsp_valid || sdram_rsp_valid || unmapped_rsp;

	// unmapped response falls through to zero
	always_comb begin
		rsp_rdata = '0;
		if (cfg_rsp_valid) begin
			rsp_rdata = cfg_rsp_rdata;
		end else if (cram0_rsp_valid) begin
			rsp_rdata = cram0_rsp_rdata;
		end else if (sdram_rsp_valid) begin
			rsp_rdata = sdram_rsp_rdata;
		end
	end

	// targets never answer over each other
	a_one_rsp: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$onehot0({cfg_rsp_valid, cram0_rsp_valid, sdram_rsp_valid, unmapped_rsp}));

endmodule

// File: source/core_config_regs.sv
`timescale 1ns/1ps
/* registers keep the low bits of each written word and read back zero-extended.
   address bits above 7 are not decoded, so the bank repeats through its region */
module core_config_regs (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic req_valid,
	input  logic req_wr,
	input  apf_io_pkg::bus_addr_t req_addr,
	input  apf_io_pkg::bus_data_t req_wdata,
	input  logic all_complete,
	input  apf_io_pkg::pad_keys_t pad1_key,
	output logic req_ready,
	output logic rsp_valid,
	output apf_io_pkg::bus_data_t rsp_rdata,
	output apf_io_pkg::ctrl_map_t ctrl_map_1,
	output apf_io_pkg::ctrl_map_t ctrl_map_2,
	output logic [apf_io_pkg::DIPSW_W-1:0] dipsw,
	output logic [apf_io_pkg::SYS_TYPE_W-1:0] system_type,
	output logic [apf_io_pkg::VIDEO_MODE_W-1:0] video_mode,
	output logic [apf_io_pkg::SND_EN_W-1:0] snd_enable,
	output logic [apf_io_pkg::CH_EN_W-1:0] ch_enable,
	output logic [apf_io_pkg::SCREEN_POS_W-1:0] screen_x_pos,
	output logic [apf_io_pkg::SCREEN_POS_W-1:0] screen_y_pos,
	output logic start_system
);
	import apf_io_pkg::*;

	cfg_index_t index;
	bus_data_t readback;

	assign index = req_addr[7:2];
	assign req_ready = 1'b1;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ctrl_map_1 <= '0;
			ctrl_map_2 <= '0;
			dipsw <= '0;
			system_type <= '0;
			video_mode <= '0;
			snd_enable <= '0;
			ch_enable <= '0;
			screen_x_pos <= '0;
			screen_y_pos <= '0;
			rsp_valid <= 1'b0;
			start_system <= 1'b0;
		end else begin
			rsp_valid <= req_valid && !req_wr;
			// core runs once loading is done and l1 is let go
			start_system <= all_complete && !pad1_key[KEY_L1];
			if (req_valid && req_wr) begin
				case (index)
					CFG_CTRL_MAP_1: ctrl_map_1 <= req_wdata[CTRL_MAP_W-1:0];
					CFG_CTRL_MAP_2: ctrl_map_2 <= req_wdata[CTRL_MAP_W-1:0];
					CFG_DIPSW: dipsw <= req_wdata[DIPSW_W-1:0];
					CFG_SYSTEM_TYPE: system_type <= req_wdata[SYS_TYPE_W-1:0];
					CFG_VIDEO_MODE: video_mode <= req_wdata[VIDEO_MODE_W-1:0];
					CFG_SND_ENABLE: snd_enable <= req_wdata[SND_EN_W-1:0];
					CFG_CH_ENABLE: ch_enable <= req_wdata[CH_EN_W-1:0];
					CFG_SCREEN_X: screen_x_pos <= req_wdata[SCREEN_POS_W-1:0];
					CFG_SCREEN_Y: screen_y_pos <= req_wdata[SCREEN_POS_W-1:0];
					default: ;
				endcase
			end
		end
	end

	// indices past the bank read as zero
	always_comb begin
		case (index)
			CFG_CTRL_MAP_1: readback = bus_data_t'(ctrl_map_1);
			CFG_CTRL_MAP_2: readback = bus_data_t'(ctrl_map_2);
			CFG_DIPSW: readback = bus_data_t'(dipsw);
			CFG_SYSTEM_TYPE: readback = bus_data_t'(system_type);
			CFG_VIDEO_MODE: readback = bus_data_t'(video_mode);
			CFG_SND_ENABLE: readback = bus_data_t'(snd_enable);
			CFG_CH_ENABLE: readback = bus_data_t'(ch_enable);
			CFG_SCREEN_X: readback = bus_data_t'(screen_x_pos);
			CFG_SCREEN_Y: readback = bus_data_t'(screen_y_pos);
			default: readback = '0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (req_valid && !req_wr) begin
			rsp_rdata <= readback;
		end
	end

endmodule

// File: source/rom_mask_tracker.sv
`timescale 1ns/1ps
/* masks only grow until reset; each write widens them to cover its offset.
   the C ROM mask uses the same rule as the P ROM mask */
module rom_mask_tracker (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic wr_p_rom,
	input  logic wr_c_rom,
	input  apf_io_pkg::bus_addr_t req_addr,
	output apf_io_pkg::p_rom_mask_t p_rom_mask,
	output apf_io_pkg::c_rom_mask_t c_rom_mask
);
	import apf_io_pkg::*;

	bus_addr_t p_smear;
	bus_addr_t c_smear;

	// all bits at and below the highest set bit
	function automatic bus_addr_t smear(input bus_addr_t value);
		bus_addr_t result;
		result[31] = value[31];
		for (int i = 30; i >= 0; i--) begin
			result[i] = result[i + 1] | value[i];
		end
		return result;
	endfunction

	// offsets are the low address bits, zero-extended before smearing
	assign p_smear = smear(bus_addr_t'(req_addr[P_ROM_MASK_W-1:0]));
	assign c_smear = smear(bus_addr_t'(req_addr[C_ROM_MASK_W-1:0]));

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			p_rom_mask <= '0;
			c_rom_mask <= '0;
		end else begin
			if (wr_p_rom) begin
				p_rom_mask <= p_rom_mask | p_smear[P_ROM_MASK_W-1:0];
			end
			if (wr_c_rom) begin
				c_rom_mask <= c_rom_mask | c_smear[C_ROM_MASK_W-1:0];
			end
		end
	end

	// a set mask bit stays set across any run of writes
	a_mask_grows: assert property (@(posedge clk_sys) disable iff (!arst_n)
		((p_rom_mask & $past(p_rom_mask)) == $past(p_rom_mask)) &&
		((c_rom_mask & $past(c_rom_mask)) == $past(c_rom_mask)));

endmodule

// File: source/pad_remap.sv
`timescale 1ns/1ps
/* key bitmaps are sampled as given, no debounce; joysticks follow one cycle later */
module pad_remap (
	input  logic clk_sys,
	input  logic arst_n,
	input  apf_io_pkg::pad_keys_t pad1_key,
	input  apf_io_pkg::pad_keys_t pad2_key,
	input  apf_io_pkg::ctrl_map_t ctrl_map_1,
	input  apf_io_pkg::ctrl_map_t ctrl_map_2,
	output apf_io_pkg::joystick_t joystick_0,
	output apf_io_pkg::joystick_t joystick_1
);
	import apf_io_pkg::*;

	function automatic joystick_t remap(input pad_keys_t keys, input ctrl_map_t layout);
		joystick_t joy;
		joy[0] = keys[KEY_RIGHT];
		joy[1] = keys[KEY_LEFT];
		joy[2] = keys[KEY_DOWN];
		joy[3] = keys[KEY_UP];
		// buttons A to D on bits 4 to 7
		case (layout)
			LAYOUT_NEOGEO: joy[7:4] = {keys[KEY_A], keys[KEY_X], keys[KEY_B], keys[KEY_Y]};
			LAYOUT_NEOGEO_CD: joy[7:4] = {keys[KEY_X], keys[KEY_Y], keys[KEY_A], keys[KEY_B]};
			default: joy[7:4] = {keys[KEY_Y], keys[KEY_X], keys[KEY_B], keys[KEY_A]};
		endcase
		joy[8] = keys[KEY_START];
		joy[9] = keys[KEY_SELECT];
		return joy;
	endfunction

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			joystick_0 <= '0;
			joystick_1 <= '0;
		end else begin
			joystick_0 <= remap(pad1_key, ctrl_map_1);
			joystick_1 <= remap(pad2_key, ctrl_map_2);
		end
	end

endmodule

// File: source/ram_window.sv
`timescale 1ns/1ps
/* one word access at a time with no byte enables, so a write replaces the whole word.
   word size must be a power of two bytes */
module ram_window #(
	parameter type word_t = apf_io_pkg::cram_word_t,
	parameter type addr_t = apf_io_pkg::cram_addr_t
) (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic req_valid,
	input  logic req_wr,
	input  apf_io_pkg::bus_addr_t req_addr,
	input  apf_io_pkg::bus_data_t req_wdata,
	output logic req_ready,
	output logic rsp_valid,
	output apf_io_pkg::bus_data_t rsp_rdata,
	output logic mem_valid,
	output logic mem_wr,
	output addr_t mem_addr,
	output word_t mem_wdata,
	input  logic mem_ready,
	input  word_t mem_rdata
);
	import apf_io_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_BUSY
	} state_t;

	state_t state;
	logic accept;

	assign req_ready = (state == ST_IDLE);
	assign accept = req_valid && req_ready;
	// the RAM request is up for exactly the busy period
	assign mem_valid = (state == ST_BUSY);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (accept) begin
						state <= ST_BUSY;
					end
				end
				ST_BUSY: begin
					if (mem_ready) begin
						state <= ST_IDLE;
						rsp_valid <= !mem_wr;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// byte offset to word address, upper bits dropped
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			mem_wr <= req_wr;
			mem_addr <= addr_t'(req_addr >> $clog2($bits(word_t) / 8));
			mem_wdata <= word_t'(req_wdata);
		end
		if (mem_valid && mem_ready) begin
			rsp_rdata <= bus_data_t'(mem_rdata);
		end
	end

	// RAM sees a steady request while it stalls
	a_req_held: assert property (@(posedge clk_sys) disable iff (!arst_n)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wr));

endmodule

// File: source/apf_io_top.sv
`timescale 1ns/1ps
/* single clock domain; pad keys and all_complete must already be synchronous to clk_sys.
   CRAM0 holds the P ROM at region 1, SDRAM the C ROM at region 4 */
module apf_io_top (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic bus_valid,
	input  logic bus_wr,
	input  apf_io_pkg::bus_addr_t bus_addr,
	input  apf_io_pkg::bus_data_t bus_wdata,
	output logic bus_ready,
	output logic rsp_valid,
	output apf_io_pkg::bus_data_t rsp_rdata,
	input  apf_io_pkg::pad_keys_t pad1_key,
	input  apf_io_pkg::pad_keys_t pad2_key,
	input  logic all_complete,
	output logic cram0_valid,
	output logic cram0_wr,
	output apf_io_pkg::cram_addr_t cram0_addr,
	output apf_io_pkg::cram_word_t cram0_wdata,
	input  logic cram0_ready,
	input  apf_io_pkg::cram_word_t cram0_rdata,
	output logic sdram_valid,
	output logic sdram_wr,
	output apf_io_pkg::sdram_addr_t sdram_addr,
	output apf_io_pkg::sdram_word_t sdram_wdata,
	input  logic sdram_ready,
	input  apf_io_pkg::sdram_word_t sdram_rdata,
	output logic [apf_io_pkg::DIPSW_W-1:0] dipsw,
	output logic [apf_io_pkg::SYS_TYPE_W-1:0] system_type,
	output logic [apf_io_pkg::VIDEO_MODE_W-1:0] video_mode,
	output logic [apf_io_pkg::SND_EN_W-1:0] snd_enable,
	output logic [apf_io_pkg::CH_EN_W-1:0] ch_enable,
	output logic [apf_io_pkg::SCREEN_POS_W-1:0] screen_x_pos,
	output logic [apf_io_pkg::SCREEN_POS_W-1:0] screen_y_pos,
	output apf_io_pkg::p_rom_mask_t p_rom_mask,
	output apf_io_pkg::c_rom_mask_t c_rom_mask,
	output apf_io_pkg::joystick_t joystick_0,
	output apf_io_pkg::joystick_t joystick_1,
	output logic start_system
);
	import apf_io_pkg::*;

	logic cfg_req_valid;
	logic cfg_req_ready;
	logic cfg_rsp_valid;
	bus_data_t cfg_rsp_rdata;
	logic cram0_req_valid;
	logic cram0_req_ready;
	logic cram0_rsp_valid;
	bus_data_t cram0_rsp_rdata;
	logic sdram_req_valid;
	logic sdram_req_ready;
	logic sdram_rsp_valid;
	bus_data_t sdram_rsp_rdata;
	logic req_wr;
	bus_addr_t req_addr;
	bus_data_t req_wdata;
	logic wr_p_rom;
	logic wr_c_rom;
	ctrl_map_t ctrl_map_1;
	ctrl_map_t ctrl_map_2;

	bridge_decode i_bridge_decode (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.bus_valid(bus_valid),
		.bus_wr(bus_wr),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.bus_ready(bus_ready),
		.rsp_valid(rsp_valid),
		.rsp_rdata(rsp_rdata),
		.cfg_req_valid(cfg_req_valid),
		.cfg_req_ready(cfg_req_ready),
		.cfg_rsp_valid(cfg_rsp_valid),
		.cfg_rsp_rdata(cfg_rsp_rdata),
		.cram0_req_valid(cram0_req_valid),
		.cram0_req_ready(cram0_req_ready),
		.cram0_rsp_valid(cram0_rsp_valid),
		.cram0_rsp_rdata(cram0_rsp_rdata),
		.sdram_req_valid(sdram_req_valid),
		.sdram_req_ready(sdram_req_ready),
		.sdram_rsp_valid(sdram_rsp_valid),
		.sdram_rsp_rdata(sdram_rsp_rdata),
		.req_wr(req_wr),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.wr_p_rom(wr_p_rom),
		.wr_c_rom(wr_c_rom)
	);

	core_config_regs i_core_config_regs (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.req_valid(cfg_req_valid),
		.req_wr(req_wr),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.all_complete(all_complete),
		.pad1_key(pad1_key),
		.req_ready(cfg_req_ready),
		.rsp_valid(cfg_rsp_valid),
		.rsp_rdata(cfg_rsp_rdata),
		.ctrl_map_1(ctrl_map_1),
		.ctrl_map_2(ctrl_map_2),
		.dipsw(dipsw),
		.system_type(system_type),
		.video_mode(video_mode),
		.snd_enable(snd_enable),
		.ch_enable(ch_enable),
		.screen_x_pos(screen_x_pos),
		.screen_y_pos(screen_y_pos),
		.start_system(start_system)
	);

	rom_mask_tracker i_rom_mask_tracker (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.wr_p_rom(wr_p_rom),
		.wr_c_rom(wr_c_rom),
		.req_addr(req_addr),
		.p_rom_mask(p_rom_mask),
		.c_rom_mask(c_rom_mask)
	);

	pad_remap i_pad_remap (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.pad1_key(pad1_key),
		.pad2_key(pad2_key),
		.ctrl_map_1(ctrl_map_1),
		.ctrl_map_2(ctrl_map_2),
		.joystick_0(joystick_0),
		.joystick_1(joystick_1)
	);

	// P ROM window, 32-bit words
	ram_window #(
		.word_t(cram_word_t),
		.addr_t(cram_addr_t)
	) i_cram0_window (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.req_valid(cram0_req_valid),
		.req_wr(req_wr),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_ready(cram0_req_ready),
		.rsp_valid(cram0_rsp_valid),
		.rsp_rdata(cram0_rsp_rdata),
		.mem_valid(cram0_valid),
		.mem_wr(cram0_wr),
		.mem_addr(cram0_addr),
		.mem_wdata(cram0_wdata),
		.mem_ready(cram0_ready),
		.mem_rdata(cram0_rdata)
	);

	// C ROM window, 16-bit words
	ram_window #(
		.word_t(sdram_word_t),
		.addr_t(sdram_addr_t)
	) i_sdram_window (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.req_valid(sdram_req_valid),
		.req_wr(req_wr),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_ready(sdram_req_ready),
		.rsp_valid(sdram_rsp_valid),
		.rsp_rdata(sdram_rsp_rdata),
		.mem_valid(sdram_valid),
		.mem_wr(sdram_wr),
		.mem_addr(sdram_addr),
		.mem_wdata(sdram_wdata),
		.mem_ready(sdram_ready),
		.mem_rdata(sdram_rdata)
	);

endmodule

// File: tb/tb_apf_io_model.svh
/* reference model of the register bank, ROM masks, pad remap and both RAM windows.
   included inside the testbench module after apf_io_pkg is imported */
`ifndef TB_APF_IO_MODEL_SVH
`define TB_APF_IO_MODEL_SVH

	bus_data_t cfg_model [0:8] = '{default: '0};
	p_rom_mask_t p_mask_exp = '0;
	c_rom_mask_t c_mask_exp = '0;
	cram_word_t exp_cram [cram_addr_t];
	sdram_word_t exp_sdram [sdram_addr_t];

	// widths from the register map, zero where no register exists
	function automatic int reg_width(input int index);
		case (index)
			0, 1, 5: return 4;
			2, 7, 8: return 8;
			3: return 2;
			4: return 1;
			6: return 6;
			default: return 0;
		endcase
	endfunction

	task automatic model_cfg_write(input int index, input bus_data_t data);
		int width;
		width = reg_width(index);
		if (width > 0) begin
			cfg_model[index] = data & 32'((64'd1 << width) - 64'd1);
		end
	endtask

	function automatic bus_data_t model_cfg_read(input int index);
		return (index <= 8) ? cfg_model[index] : 32'h0;
	endfunction

	// ones from the highest set bit down to bit 0
	function automatic logic [31:0] smear_of(input logic [31:0] value);
		logic [31:0] result;
		result = '0;
		for (int b = 0; b < 32; b++) begin
			if (value[b]) begin
				result = (b == 31) ? 32'hffff_ffff : ((32'd1 << (b + 1)) - 32'd1);
			end
		end
		return result;
	endfunction

	// byte offset within the region divided by the word size
	function automatic cram_addr_t cram_word_addr(input bus_addr_t addr);
		return cram_addr_t'(addr[27:0] / 28'd4);
	endfunction

	function automatic sdram_addr_t sdram_word_addr(input bus_addr_t addr);
		return sdram_addr_t'(addr[27:0] / 28'd2);
	endfunction

	// contents of never written words, folded from every address bit
	function automatic cram_word_t cram_fill(input cram_addr_t addr);
		return {~addr[7:0], addr};
	endfunction

	function automatic sdram_word_t sdram_fill(input sdram_addr_t addr);
		return addr[15:0] ^ {6'h2a, addr[25:16]};
	endfunction

	task automatic model_mem_write(input bus_addr_t addr, input bus_data_t data);
		if (addr[31:28] == 4'h1) begin
			exp_cram[cram_word_addr(addr)] = data;
			p_mask_exp = p_mask_exp | 24'(smear_of(32'(addr[23:0])));
		end else if (addr[31:28] == 4'h4) begin
			exp_sdram[sdram_word_addr(addr)] = data[15:0];
			c_mask_exp = c_mask_exp | 26'(smear_of(32'(addr[25:0])));
		end
	endtask

	function automatic bus_data_t model_mem_read(input bus_addr_t addr);
		cram_addr_t ca;
		sdram_addr_t sa;
		ca = cram_word_addr(addr);
		sa = sdram_word_addr(addr);
		if (addr[31:28] == 4'h1) begin
			return exp_cram.exists(ca) ? exp_cram[ca] : cram_fill(ca);
		end
		return 32'(exp_sdram.exists(sa) ? exp_sdram[sa] : sdram_fill(sa));
	endfunction

	// joystick bits: right, left, down, up, four buttons, start, select
	function automatic joystick_t remap_model(input pad_keys_t k, input logic [3:0] layout);
		logic [3:0] buttons;
		if (layout == 4'd1) begin
			buttons[0] = k[7];
			buttons[1] = k[5];
			buttons[2] = k[6];
			buttons[3] = k[4];
		end else if (layout == 4'd2) begin
			buttons[0] = k[5];
			buttons[1] = k[4];
			buttons[2] = k[7];
			buttons[3] = k[6];
		end else begin
			buttons = k[7:4];
		end
		return {k[14], k[15], buttons, k[0], k[1], k[2], k[3]};
	endfunction

`endif

// File: tb/tb_apf_io.sv
`timescale 1ns/1ps
/* random host traffic checked against a model; both RAM ports answered by arrays
   with 0 to 3 cycles of back-pressure. the first error ends the run */
module tb_apf_io;
	import apf_io_pkg::*;

	localparam int TIMEOUT_CYCLES = 200;

	logic clk_sys = 1'b0;
	logic arst_n;
	logic bus_valid;
	logic bus_wr;
	bus_addr_t bus_addr;
	bus_data_t bus_wdata;
	logic bus_ready;
	logic rsp_valid;
	bus_data_t rsp_rdata;
	pad_keys_t pad1_key;
	pad_keys_t pad2_key;
	logic all_complete;
	logic cram0_valid;
	logic cram0_wr;
	cram_addr_t cram0_addr;
	cram_word_t cram0_wdata;
	logic cram0_ready;
	cram_word_t cram0_rdata;
	logic sdram_valid;
	logic sdram_wr;
	sdram_addr_t sdram_addr;
	sdram_word_t sdram_wdata;
	logic sdram_ready;
	sdram_word_t sdram_rdata;
	logic [7:0] dipsw;
	logic [1:0] system_type;
	logic [0:0] video_mode;
	logic [3:0] snd_enable;
	logic [5:0] ch_enable;
	logic [7:0] screen_x_pos;
	logic [7:0] screen_y_pos;
	p_rom_mask_t p_rom_mask;
	c_rom_mask_t c_rom_mask;
	joystick_t joystick_0;
	joystick_t joystick_1;
	logic start_system;
	cram_word_t cram_mem [cram_addr_t];
	sdram_word_t sdram_mem [sdram_addr_t];

	`include "tb_apf_io_model.svh"

	apf_io_top i_apf_io_top (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.bus_valid(bus_valid),
		.bus_wr(bus_wr),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.bus_ready(bus_ready),
		.rsp_valid(rsp_valid),
		.rsp_rdata(rsp_rdata),
		.pad1_key(pad1_key),
		.pad2_key(pad2_key),
		.all_complete(all_complete),
		.cram0_valid(cram0_valid),
		.cram0_wr(cram0_wr),
		.cram0_addr(cram0_addr),
		.cram0_wdata(cram0_wdata),
		.cram0_ready(cram0_ready),
		.cram0_rdata(cram0_rdata),
		.sdram_valid(sdram_valid),
		.sdram_wr(sdram_wr),
		.sdram_addr(sdram_addr),
		.sdram_wdata(sdram_wdata),
		.sdram_ready(sdram_ready),
		.sdram_rdata(sdram_rdata),
		.dipsw(dipsw),
		.system_type(system_type),
		.video_mode(video_mode),
		.snd_enable(snd_enable),
		.ch_enable(ch_enable),
		.screen_x_pos(screen_x_pos),
		.screen_y_pos(screen_y_pos),
		.p_rom_mask(p_rom_mask),
		.c_rom_mask(c_rom_mask),
		.joystick_0(joystick_0),
		.joystick_1(joystick_1),
		.start_system(start_system)
	);

	always #20 clk_sys = ~clk_sys;

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic stop_with_failure();
		$display("Something failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic timed_out(input string what);
		$display("timeout: no %s within %0d cycles", what, TIMEOUT_CYCLES);
		stop_with_failure();
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	// one bridge transfer; reads also wait for the response
	task automatic bus_access(input logic wr, input bus_addr_t addr, input bus_data_t data,
		output bus_data_t rdata);
		int cycles;
		logic taken;
		cycles = 0;
		taken = 1'b0;
		rdata = '0;
		bus_valid = 1'b1;
		bus_wr = wr;
		bus_addr = addr;
		bus_wdata = data;
		while (!taken) begin
			@(posedge clk_sys);
			taken = bus_ready;
			cycles++;
			if (!taken && cycles >= TIMEOUT_CYCLES) begin
				timed_out("bus_ready");
			end
		end
		#2;
		bus_valid = 1'b0;
		if (!wr) begin
			cycles = 0;
			taken = 1'b0;
			while (!taken) begin
				@(posedge clk_sys);
				taken = rsp_valid;
				rdata = rsp_rdata;
				cycles++;
				if (!taken && cycles >= TIMEOUT_CYCLES) begin
					timed_out("rsp_valid");
				end
			end
			#2;
		end
	endtask

	task automatic wait_windows_idle();
		int cycles;
		cycles = 0;
		while (cram0_valid || sdram_valid) begin
			next_cycle();
			cycles++;
			if (cycles >= TIMEOUT_CYCLES) begin
				timed_out("end of the RAM access");
			end
		end
	endtask

	function automatic bus_addr_t cfg_addr(input int index);
		return {4'hf, 20'h0, 6'(index), 2'b00};
	endfunction

	function automatic cram_word_t cram_word_at(input cram_addr_t addr);
		return cram_mem.exists(addr) ? cram_mem[addr] : cram_fill(addr);
	endfunction

	function automatic sdram_word_t sdram_word_at(input sdram_addr_t addr);
		return sdram_mem.exists(addr) ? sdram_mem[addr] : sdram_fill(addr);
	endfunction

	task automatic check_config_outputs();
		check_value("dipsw", 32'(dipsw), cfg_model[2]);
		check_value("system_type", 32'(system_type), cfg_model[3]);
		check_value("video_mode", 32'(video_mode), cfg_model[4]);
		check_value("snd_enable", 32'(snd_enable), cfg_model[5]);
		check_value("ch_enable", 32'(ch_enable), cfg_model[6]);
		check_value("screen_x_pos", 32'(screen_x_pos), cfg_model[7]);
		check_value("screen_y_pos", 32'(screen_y_pos), cfg_model[8]);
	endtask

	task automatic check_masks();
		check_value("p_rom_mask", 32'(p_rom_mask), 32'(p_mask_exp));
		check_value("c_rom_mask", 32'(c_rom_mask), 32'(c_mask_exp));
	endtask

	// RAM ports, ready comes after 0 to 3 waiting cycles
	initial begin
		logic [31:0] cram_seed;
		logic [31:0] sdram_seed;
		int cram_wait;
		int sdram_wait;
		cram_seed = lcg(32'hd95);
		sdram_seed = lcg(cram_seed);
		cram_wait = -1;
		sdram_wait = -1;
		cram0_ready = 1'b0;
		cram0_rdata = '0;
		sdram_ready = 1'b0;
		sdram_rdata = '0;
		forever begin
			@(posedge clk_sys);
			if (cram0_valid && cram0_ready && cram0_wr) begin
				cram_mem[cram0_addr] = cram0_wdata;
			end
			if (sdram_valid && sdram_ready && sdram_wr) begin
				sdram_mem[sdram_addr] = sdram_wdata;
			end
			#2;
			if (cram0_ready || !cram0_valid) begin
				cram0_ready = 1'b0;
				cram_wait = -1;
			end else begin
				if (cram_wait < 0) begin
					cram_seed = lcg(cram_seed);
					cram_wait = int'(cram_seed[25:24]);
				end
				if (cram_wait == 0) begin
					cram0_ready = 1'b1;
					cram0_rdata = cram_word_at(cram0_addr);
				end else begin
					cram_wait--;
				end
			end
			if (sdram_ready || !sdram_valid) begin
				sdram_ready = 1'b0;
				sdram_wait = -1;
			end else begin
				if (sdram_wait < 0) begin
					sdram_seed = lcg(sdram_seed);
					sdram_wait = int'(sdram_seed[25:24]);
				end
				if (sdram_wait == 0) begin
					sdram_ready = 1'b1;
					sdram_rdata = sdram_word_at(sdram_addr);
				end else begin
					sdram_wait--;
				end
			end
		end
	end

	initial begin
		logic [31:0] seed;
		bus_addr_t addr;
		bus_data_t data;
		bus_data_t rdata;
		int idx;
		bus_addr_t written [$];
		seed = 32'hd95;
		arst_n = 1'b0;
		bus_valid = 1'b0;
		bus_wr = 1'b0;
		bus_addr = '0;
		bus_wdata = '0;
		pad1_key = '0;
		pad2_key = '0;
		all_complete = 1'b0;
		repeat (16) @(posedge clk_sys);
		#2;
		check_value("bus_ready", 32'(bus_ready), 32'h0);
		check_value("rsp_valid", 32'(rsp_valid), 32'h0);
		check_value("cram0_valid", 32'(cram0_valid), 32'h0);
		check_value("sdram_valid", 32'(sdram_valid), 32'h0);
		check_value("start_system", 32'(start_system), 32'h0);
		check_value("joystick_0", 32'(joystick_0), 32'h0);
		check_value("joystick_1", 32'(joystick_1), 32'h0);
		check_config_outputs();
		check_masks();
		arst_n = 1'b1;
		next_cycle();

		// config writes including indices past the bank, then full readback
		for (int n = 0; n < 40; n++) begin
			seed = lcg(seed);
			idx = int'(seed[31:16]) % 11;
			seed = lcg(seed);
			bus_access(1'b1, cfg_addr(idx), seed, rdata);
			model_cfg_write(idx, seed);
			check_config_outputs();
			check_value("rsp_valid", 32'(rsp_valid), 32'h0);
		end
		for (int i = 0; i < 11; i++) begin
			bus_access(1'b0, cfg_addr(i), '0, rdata);
			check_value("config rsp_rdata", rdata, model_cfg_read(i));
		end

		// offsets widen over the run so the masks grow step by step
		for (int n = 0; n < 58; n++) begin
			seed = lcg(seed);
			addr = {seed[31] ? 4'h1 : 4'h4, 28'(seed[27:0] >> (28 - n / 2))};
			seed = lcg(seed);
			data = seed;
			bus_access(1'b1, addr, data, rdata);
			model_mem_write(addr, data);
			written.push_back(addr);
			check_masks();
			wait_windows_idle();
			check_value("rsp_valid", 32'(rsp_valid), 32'h0);
			if (addr[31:28] == 4'h1) begin
				check_value("cram0 word", cram_word_at(cram_word_addr(addr)), data);
			end else begin
				check_value("sdram word", 32'(sdram_word_at(sdram_word_addr(addr))),
					32'(data[15:0]));
			end
		end
		while (written.size() > 0) begin
			addr = written.pop_back();
			bus_access(1'b0, addr, '0, rdata);
			check_value("window rsp_rdata", rdata, model_mem_read(addr));
		end

		// layouts 0, 1, 2 and any code
		for (int n = 0; n < 30; n++) begin
			for (int p = 0; p < 2; p++) begin
				seed = lcg(seed);
				data = (seed[29:28] == 2'd3) ? 32'(seed[27:24]) : 32'(seed[29:28]);
				bus_access(1'b1, cfg_addr(p), data, rdata);
				model_cfg_write(p, data);
			end
			seed = lcg(seed);
			pad1_key = seed[15:0];
			pad2_key = seed[31:16];
			next_cycle();
			check_value("joystick_0", 32'(joystick_0),
				32'(remap_model(pad1_key, cfg_model[0][3:0])));
			check_value("joystick_1", 32'(joystick_1),
				32'(remap_model(pad2_key, cfg_model[1][3:0])));
		end

		// region 7 is unmapped
		for (int n = 0; n < 20; n++) begin
			seed = lcg(seed);
			addr = {4'h7, seed[27:0]};
			bus_access(1'b1, addr, lcg(seed), rdata);
			check_value("cram0_valid", 32'(cram0_valid), 32'h0);
			check_value("sdram_valid", 32'(sdram_valid), 32'h0);
			check_config_outputs();
			check_masks();
			bus_access(1'b0, addr, '0, rdata);
			check_value("unmapped rsp_rdata", rdata, 32'h0);
			seed = lcg(seed);
			all_complete = seed[30];
			pad1_key = seed[15:0];
			next_cycle();
			check_value("start_system", 32'(start_system),
				32'(all_complete && !pad1_key[8]));
		end

		$display("Everything OK");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+tb
source/apf_io_pkg.sv
source/bridge_decode.sv
source/core_config_regs.sv
source/rom_mask_tracker.sv
source/pad_remap.sv
source/ram_window.sv
source/apf_io_top.sv
tb/tb_apf_io.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it; the exit status is the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f verilog.f --top-module tb_apf_io -Mdir obj_dir -o tb_apf_io
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build returned $status"
	exit $status
fi

./obj_dir/tb_apf_io
status=$?
if [ $status -ne 0 ]; then
	echo "simulation returned $status"
	exit $status
fi

exit 0
